// ==== Makefile ====
# Verilator build and run for the rx statistics testbench
# override on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= rx_stats_tb
LOG       ?= sim.log
FLAGS     ?= --binary --timing -Wno-fatal

FILELIST := filelist.f
SRCS     := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS     := $(wildcard hdl/*.svh)
BIN      := obj_dir/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the log holds the pass line
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
+incdir+hdl
hdl/stats_pkg.sv
hdl/rx_stat_counters.sv
hdl/stat_sync.sv
hdl/stat_read_port.sv
hdl/rx_stats_top.sv
test/rx_stats_tb.sv

// ==== hdl/rx_stat_counters.sv ====
/*
 * line side frame counters
 * classifies each rx event as good or bad crc and bumps the
 * good, bad, byte and broadcast counters, all wrapping
 */
`timescale 1ns/1ps
`include "stats_macros.svh"

module rx_stat_counters (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  stats_pkg::rx_event_t   rx_event,  // one frame per valid cycle
    output stats_pkg::stat_bank_t  bank
);

    ////////////////////////////////////////////////////////////////////////////
    // event classification

    logic                    good_frame;   // valid and crc ok
    logic                    bad_frame;    // valid and crc failed
    logic                    bcast_frame;  // good broadcast only
    logic [`STATS_CNT_W-1:0] len_ext;      // length widened to counter size

    assign good_frame  = rx_event.valid & ~rx_event.bad_crc;
    assign bad_frame   = rx_event.valid &  rx_event.bad_crc;
    assign bcast_frame = good_frame & rx_event.bcast;

    // zero extend, len is always narrower than a counter
    assign len_ext = `STATS_CNT_W'(rx_event.len);

    ////////////////////////////////////////////////////////////////////////////
    // counters

    // frame counters, one increment per event at most
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            bank.good_frames  <= '0;
            bank.bad_frames   <= '0;
            bank.bcast_frames <= '0;
        end else begin
            if (good_frame) begin
                bank.good_frames <= bank.good_frames + 1'b1;  // wraps
            end
            if (bad_frame) begin
                bank.bad_frames <= bank.bad_frames + 1'b1;
            end
            if (bcast_frame) begin
                bank.bcast_frames <= bank.bcast_frames + 1'b1;
            end
        end
    end

    // byte counter
    // bad crc lengths are not counted, the frame is dropped upstream
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            bank.good_bytes <= '0;
        end else if (good_frame) begin
            bank.good_bytes <= bank.good_bytes + len_ext;  // wraps mod 2^32
        end
    end

endmodule

// ==== hdl/rx_stats_top.sv ====
/*
 * rx statistics top level
 * line side counters, bank synchronizer into the host clock,
 * credit based read port
 */
`timescale 1ns/1ps

module rx_stats_top (
    // line side
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  stats_pkg::rx_event_t rx_event,
    // host side
    input  logic                 clk_out,   // faster than clk_in
    input  logic                 rst_out,
    input  stats_pkg::rd_req_t   rd_req,
    input  logic                 credit_in,
    output stats_pkg::rd_rsp_t   rd_rsp
);

    import stats_pkg::*;

    stat_bank_t bank_line;  // live counters, clk_in
    stat_bank_t bank_host;  // snapshot, clk_out

    ////////////////////////////////////////////////////////////////////////////
    // line domain

    rx_stat_counters rx_stat_counters_inst (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .rx_event (rx_event),
        .bank     (bank_line)
    );

    ////////////////////////////////////////////////////////////////////////////
    // crossing, whole bank in one vector

    stat_sync #(
        .W ($bits(stat_bank_t))
    ) stat_sync_inst (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .clk_out (clk_out),
        .rst_out (rst_out),
        .din     (bank_line),
        .dout    (bank_host)
    );

    ////////////////////////////////////////////////////////////////////////////
    // host domain

    stat_read_port stat_read_port_inst (
        .clk_out   (clk_out),
        .rst_out   (rst_out),
        .bank      (bank_host),
        .rd_req    (rd_req),
        .credit_in (credit_in),
        .rd_rsp    (rd_rsp)
    );

endmodule

// ==== hdl/stat_read_port.sv ====
/*
 * host side read port
 * request fifo, credit counter and registered response
 * a request goes straight through when the fifo is empty
 */
`timescale 1ns/1ps
`include "stats_macros.svh"

module stat_read_port (
    input  logic                  clk_out,
    input  logic                  rst_out,
    input  stats_pkg::stat_bank_t bank,       // synchronized snapshot
    input  stats_pkg::rd_req_t    rd_req,
    input  logic                  credit_in,  // one credit back per cycle
    output stats_pkg::rd_rsp_t    rd_rsp
);

    import stats_pkg::*;

    localparam int DEPTH = `STATS_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CRD_W = $clog2(`STATS_CREDITS + 1);

    // request fifo
    stat_sel_e  fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fifo_cnt;
    logic             fifo_empty;
    logic             fifo_full;
    logic             push;
    logic             pop;

    // issue path
    logic [CRD_W-1:0]        credits;
    logic                    cur_valid;  // something to answer this cycle
    stat_sel_e               cur_sel;
    logic                    issue;
    logic [`STATS_CNT_W-1:0] sel_value;

    // response regs
    logic                    rsp_valid;
    stat_sel_e               rsp_sel;
    logic [`STATS_CNT_W-1:0] rsp_value;

    ////////////////////////////////////////////////////////////////////////////
    // queue

    assign fifo_empty = (fifo_cnt == '0);
    assign fifo_full  = (fifo_cnt == (PTR_W+1)'(DEPTH));

    // oldest request first, bypass when nothing is queued
    assign cur_valid = ~fifo_empty | rd_req.valid;
    assign cur_sel   = fifo_empty ? rd_req.sel : fifo_mem[rd_ptr];
    assign issue     = cur_valid & (credits != '0);

    assign pop  = issue & ~fifo_empty;
    assign push = rd_req.valid & ~(fifo_empty & issue) & ~fifo_full;

    always_ff @(posedge clk_out) begin
        if (rst_out) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk_out) begin
        if (push) begin
            fifo_mem[wr_ptr] <= rd_req.sel;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // credits, return and spend may land in the same cycle

    always_ff @(posedge clk_out) begin
        if (rst_out) begin
            credits <= CRD_W'(`STATS_CREDITS);
        end else begin
            case ({credit_in, issue})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // response

    always_comb begin
        case (cur_sel)
            SEL_GOOD_FRAMES:  sel_value = bank.good_frames;
            SEL_BAD_FRAMES:   sel_value = bank.bad_frames;
            SEL_GOOD_BYTES:   sel_value = bank.good_bytes;
            SEL_BCAST_FRAMES: sel_value = bank.bcast_frames;
            default:          sel_value = '0;
        endcase
    end

    always_ff @(posedge clk_out) begin
        if (rst_out) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= issue;
        end
    end

    // payload, value is whatever the bank holds on the issue cycle
    always_ff @(posedge clk_out) begin
        if (issue) begin
            rsp_sel   <= cur_sel;
            rsp_value <= sel_value;
        end
    end

    assign rd_rsp = '{valid: rsp_valid, sel: rsp_sel, value: rsp_value};

endmodule

// ==== hdl/stat_sync.sv ====
/*
 * periodic snapshot synchronizer, clk_in to clk_out
 * source fsm captures din, sends one pulse, then holds the crossing
 * register; destination syncs the pulse and loads dout
 * requires clk_out faster than clk_in
 */
`timescale 1ns/1ps

module stat_sync #(
    parameter int W = 32  // vector width
) (
    input  logic         clk_in,
    input  logic         rst_in,
    input  logic         clk_out,  // must be faster than clk_in
    input  logic         rst_out,
    input  logic [W-1:0] din,
    output logic [W-1:0] dout
);

    import stats_pkg::*;

    // source side
    sync_src_state_e src_state;
    logic            sync_pulse;  // registered, one clk_in cycle wide
    logic [W-1:0]    cross_q;     // stable while the pulse is in flight

    // destination side
    sync_dst_state_e dst_state;
    logic            sync_meta;   // first flop, may go metastable
    logic            sync_q;      // second flop, safe to use

    ////////////////////////////////////////////////////////////////////////////
    // source fsm, clk_in

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            src_state  <= SRC_IDLE;
            sync_pulse <= 1'b0;
        end else begin
            sync_pulse <= 1'b0;  // default low
            case (src_state)
                SRC_IDLE:    src_state <= SRC_CAPTURE;
                SRC_CAPTURE: src_state <= SRC_PULSE;  // cross_q loads here
                SRC_PULSE: begin
                    sync_pulse <= 1'b1;               // high during hold1
                    src_state  <= SRC_HOLD1;
                end
                // quiet time, far side samples cross_q somewhere in here
                SRC_HOLD1:   src_state <= SRC_HOLD2;
                SRC_HOLD2:   src_state <= SRC_HOLD3;
                SRC_HOLD3:   src_state <= SRC_HOLD4;
                SRC_HOLD4:   src_state <= SRC_HOLD5;
                SRC_HOLD5:   src_state <= SRC_IDLE;
                default:     src_state <= SRC_IDLE;   // illegal encoding
            endcase
        end
    end

    // crossing register, only changes in capture
    always_ff @(posedge clk_in) begin
        if (src_state == SRC_CAPTURE) begin
            cross_q <= din;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // destination, clk_out

    always_ff @(posedge clk_out) begin
        if (rst_out) begin
            dst_state <= DST_INIT;
            sync_meta <= 1'b0;
            sync_q    <= 1'b0;
        end else begin
            sync_meta <= sync_pulse;  // async input
            sync_q    <= sync_meta;
            case (dst_state)
                DST_INIT: dst_state <= DST_RUN;
                DST_RUN:  dst_state <= DST_RUN;
                default:  dst_state <= DST_INIT;
            endcase
        end
    end

    // output latch
    // pulse may be seen for two clk_out cycles, same value both times
    always_ff @(posedge clk_out) begin
        if (dst_state == DST_INIT) begin
            dout <= '0;
        end else if (sync_q) begin
            dout <= cross_q;  // quiet by now
        end
    end

endmodule

// ==== hdl/stats_macros.svh ====
/*
 * shared widths and limits for the rx statistics block
 * counter and length widths, counter count, response credits,
 * synchronizer sample period
 */
`ifndef STATS_MACROS_SVH
`define STATS_MACROS_SVH

// counter bank
`define STATS_CNT_W         32  // bits per counter, wraps
`define STATS_NUM_CNT       4   // good, bad, bytes, bcast
`define STATS_LEN_W         14  // frame length field, up to 16383 bytes

// host side
`define STATS_CREDITS       4   // credits after reset, also request queue depth

// crossing
`define STATS_SAMPLE_PERIOD 8   // clk_in cycles per snapshot

`endif

// ==== hdl/stats_pkg.sv ====
/*
 * types for the rx statistics block
 * frame event, counter bank, read request and response structs,
 * counter select opcodes, synchronizer state encodings
 */
`include "stats_macros.svh"

package stats_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // line side

    // one decoded frame, valid for exactly one clk_in cycle
    typedef struct packed {
        logic                    valid;
        logic [`STATS_LEN_W-1:0] len;      // bytes in frame
        logic                    bad_crc;  // fcs check failed
        logic                    bcast;    // da was ff:ff:ff:ff:ff:ff
    } rx_event_t;

    // counter select opcodes
    typedef enum logic [$clog2(`STATS_NUM_CNT)-1:0] {
        SEL_GOOD_FRAMES  = 2'd0,
        SEL_BAD_FRAMES   = 2'd1,
        SEL_GOOD_BYTES   = 2'd2,
        SEL_BCAST_FRAMES = 2'd3
    } stat_sel_e;

    // whole bank, crosses domains as one vector
    typedef struct packed {
        logic [`STATS_CNT_W-1:0] good_frames;
        logic [`STATS_CNT_W-1:0] bad_frames;
        logic [`STATS_CNT_W-1:0] good_bytes;
        logic [`STATS_CNT_W-1:0] bcast_frames;
    } stat_bank_t;

    ////////////////////////////////////////////////////////////////////////////
    // host side

    typedef struct packed {
        logic      valid;
        stat_sel_e sel;
    } rd_req_t;

    typedef struct packed {
        logic                    valid;
        stat_sel_e               sel;    // echoed from the request
        logic [`STATS_CNT_W-1:0] value;
    } rd_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // synchronizer states

    // idle is all zero, one bit for each of the other states
    localparam int SRC_W = `STATS_SAMPLE_PERIOD - 1;

    typedef enum logic [SRC_W-1:0] {
        SRC_IDLE    = SRC_W'(0),
        SRC_CAPTURE = SRC_W'(1 << 0),
        SRC_PULSE   = SRC_W'(1 << 1),
        SRC_HOLD1   = SRC_W'(1 << 2),
        SRC_HOLD2   = SRC_W'(1 << 3),
        SRC_HOLD3   = SRC_W'(1 << 4),
        SRC_HOLD4   = SRC_W'(1 << 5),
        SRC_HOLD5   = SRC_W'(1 << 6)
    } sync_src_state_e;

    typedef enum logic {
        DST_INIT = 1'b0,  // one cycle after reset, clears output
        DST_RUN  = 1'b1
    } sync_dst_state_e;

endpackage

// ==== test/rx_stats_tb.sv ====
/*
 * testbench for the rx statistics block
 * two clocks and resets, frame stimulus table, counter reference model,
 * host reads with credit return, ordering and back-pressure checks
 */
`timescale 1ns/1ps
`include "stats_macros.svh"

module rx_stats_tb;

    import stats_pkg::*;

    localparam int NUM_ROWS      = 14;
    localparam int PHASE1_ROWS   = 8;    // rows 0..7 first, rest after the host tests
    localparam int MAX_GAP       = 3;    // idle clk_in cycles after a frame
    localparam int NUM_READS     = 25;   // 3 banks of 4, 4 ordered, 9 credit test
    localparam int RSP_WAIT      = 20;   // clk_out cycles allowed per response
    localparam int SETTLE_CYCLES = 4 * `STATS_SAMPLE_PERIOD;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (1 + MAX_GAP) + NUM_READS * 20 + 200;

    // one stimulus row
    typedef struct packed {
        logic [`STATS_LEN_W-1:0] len;
        logic                    bad_crc;
        logic                    bcast;
        logic [3:0]              gap;      // filled from $random
    } frame_row_t;

    logic      clk_in  = 1'b0;
    logic      clk_out = 1'b0;
    logic      rst_in  = 1'b1;
    logic      rst_out = 1'b1;
    rx_event_t rx_event;
    rd_req_t   rd_req;
    logic      credit_in;
    rd_rsp_t   rd_rsp;

    frame_row_t frame_table [NUM_ROWS];
    rd_rsp_t    rsp_q [$];                 // responses seen on the host side
    integer     seed        = 32'h5188e530;
    int         cycle_count = 0;

    // reference model of the counter bank
    logic [`STATS_CNT_W-1:0] exp_good;
    logic [`STATS_CNT_W-1:0] exp_bad;
    logic [`STATS_CNT_W-1:0] exp_bytes;
    logic [`STATS_CNT_W-1:0] exp_bcast;

    rx_stats_top rx_stats_top_inst (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .rx_event  (rx_event),
        .clk_out   (clk_out),
        .rst_out   (rst_out),
        .rd_req    (rd_req),
        .credit_in (credit_in),
        .rd_rsp    (rd_rsp)
    );

    ////////////////////////////////////////////////////////////////////////////
    // clocks, resets, watchdog, response monitor

    initial begin
        forever #10 clk_in = ~clk_in;      // 20 ns line clock
    end

    initial begin
        forever #6 clk_out = ~clk_out;     // 12 ns host clock
    end

    initial begin
        repeat (3) @(posedge clk_in);
        #2 rst_in = 1'b0;
    end

    initial begin
        repeat (3) @(posedge clk_out);
        #2 rst_out = 1'b0;
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("simulation ran past its cycle limit");
        end
    end

    // response regs are stable mid cycle
    always @(negedge clk_out) begin
        if (!rst_out && rd_rsp.valid) begin
            rsp_q.push_back(rd_rsp);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // model lookup by opcode
    function automatic logic [`STATS_CNT_W-1:0] expected_value(input stat_sel_e sel);
        case (sel)
            SEL_GOOD_FRAMES:  return exp_good;
            SEL_BAD_FRAMES:   return exp_bad;
            SEL_GOOD_BYTES:   return exp_bytes;
            default:          return exp_bcast;
        endcase
    endfunction

    task automatic check_rsp(input rd_rsp_t rsp, input stat_sel_e sel);
        check_value("rd_rsp.sel", 32'(rsp.sel), 32'(sel));  // echo
        check_value($sformatf("rd_rsp.value[%s]", sel.name()), rsp.value,
                    expected_value(sel));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // line side stimulus

    task automatic set_row(input int idx, input int len, input logic bad, input logic bc);
        frame_table[idx].len     = `STATS_LEN_W'(len);
        frame_table[idx].bad_crc = bad;
        frame_table[idx].bcast   = bc;
        frame_table[idx].gap     = 4'($unsigned($random(seed)) % (MAX_GAP + 1));
    endtask

    task automatic load_table();
        set_row(0,    64, 1'b0, 1'b0);
        set_row(1,  1518, 1'b0, 1'b1);
        set_row(2,   128, 1'b1, 1'b0);     // bad crc so length not counted
        set_row(3,  9000, 1'b0, 1'b0);     // jumbo
        set_row(4,    60, 1'b0, 1'b1);
        set_row(5,   512, 1'b1, 1'b1);     // bad broadcast counts as bad only
        set_row(6,   256, 1'b0, 1'b0);
        set_row(7,  1024, 1'b0, 1'b1);
        set_row(8, 16383, 1'b0, 1'b0);     // largest length field
        set_row(9,    64, 1'b1, 1'b0);
        set_row(10,  100, 1'b0, 1'b1);
        set_row(11,  700, 1'b0, 1'b0);
        set_row(12, 1500, 1'b1, 1'b0);
        set_row(13,   66, 1'b0, 1'b1);
    endtask

    // one frame event, then the row's idle gap
    task automatic apply_frame(input frame_row_t row);
        @(posedge clk_in);
        #2 rx_event = '{valid: 1'b1, len: row.len, bad_crc: row.bad_crc, bcast: row.bcast};
        if (row.bad_crc) begin
            exp_bad = exp_bad + 1;
        end else begin
            exp_good  = exp_good + 1;
            exp_bytes = exp_bytes + `STATS_CNT_W'(row.len);
            if (row.bcast) begin
                exp_bcast = exp_bcast + 1;
            end
        end
        repeat (row.gap) begin
            @(posedge clk_in);
            #2 rx_event.valid = 1'b0;
        end
    endtask

    task automatic run_rows(input int first, input int last);
        for (int k = first; k <= last; k++) begin
            apply_frame(frame_table[k]);
        end
        @(posedge clk_in);
        #2 rx_event.valid = 1'b0;
        repeat (SETTLE_CYCLES) @(posedge clk_in);  // let a fresh snapshot land
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // host side

    task automatic drive_request(input stat_sel_e sel);
        @(posedge clk_out);
        #2 rd_req = '{valid: 1'b1, sel: sel};
    endtask

    task automatic end_requests();
        @(posedge clk_out);
        #2 rd_req.valid = 1'b0;
    endtask

    task automatic return_credits(input int n);
        repeat (n) begin
            @(posedge clk_out);
            #2 credit_in = 1'b1;           // one credit per cycle high
        end
        @(posedge clk_out);
        #2 credit_in = 1'b0;
    endtask

    task automatic wait_response(output rd_rsp_t rsp);
        int waited;
        waited = 0;
        while (rsp_q.size() == 0) begin
            if (waited == RSP_WAIT) begin
                abort_run("no response from the read port in time");
            end
            @(posedge clk_out);
            waited++;
        end
        rsp = rsp_q.pop_front();
    endtask

    task automatic expect_no_response(input int n);
        repeat (n) @(posedge clk_out);
        if (rsp_q.size() != 0) begin
            abort_run("read port answered without a credit to spend");
        end
    endtask

    // single read with its credit returned after the response
    task automatic read_and_check(input stat_sel_e sel);
        rd_rsp_t rsp;
        drive_request(sel);
        end_requests();
        wait_response(rsp);
        check_rsp(rsp, sel);
        return_credits(1);
    endtask

    task automatic read_bank();
        for (int s = 0; s < `STATS_NUM_CNT; s++) begin
            read_and_check(stat_sel_e'(s));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        rd_rsp_t rsp;
        rx_event  = '0;
        rd_req    = '0;
        credit_in = 1'b0;
        exp_good  = '0;
        exp_bad   = '0;
        exp_bytes = '0;
        exp_bcast = '0;
        load_table();
        wait (!rst_in && !rst_out);

        read_bank();                                 // all zero after reset

        run_rows(0, PHASE1_ROWS - 1);                // good, bad, bcast, bytes
        read_bank();

        // back to back reads in reverse selector order
        for (int i = 0; i < `STATS_CREDITS; i++) begin
            drive_request(stat_sel_e'(3 - i));
        end
        end_requests();
        for (int i = 0; i < `STATS_CREDITS; i++) begin
            wait_response(rsp);
            check_rsp(rsp, stat_sel_e'(3 - i));
        end
        return_credits(`STATS_CREDITS);

        // two full bursts, credits come back only after the first
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < `STATS_CREDITS; i++) begin
                drive_request(stat_sel_e'(i));
            end
            end_requests();
            for (int i = 0; i < `STATS_CREDITS; i++) begin
                wait_response(rsp);
                check_rsp(rsp, stat_sel_e'(i));
            end
            if (pass == 0) begin
                return_credits(`STATS_CREDITS);
            end
        end
        // ninth request parks in the queue with no credits left
        drive_request(SEL_GOOD_BYTES);
        end_requests();
        expect_no_response(RSP_WAIT);
        return_credits(1);
        wait_response(rsp);
        check_rsp(rsp, SEL_GOOD_BYTES);
        expect_no_response(RSP_WAIT);                // exactly one came out
        return_credits(`STATS_CREDITS);

        run_rows(PHASE1_ROWS, NUM_ROWS - 1);         // sampling keeps running
        read_bank();

        $display("No errors");
        $finish;
    end

endmodule
